// File: common/sinvar_pkg.sv
package sinvar_pkg;

    // Prescale setting selects a tick every 2^prescale clocks
    parameter int PRESCALE_W = 3;

    // Duty level and tick-in-frame share one width, 16 ticks per frame
    parameter int LEVEL_W = 4;

    // Sample index, 16 samples per sine period
    parameter int IDX_W = 4;

    // Index bits left once the two quadrant bits are taken off
    parameter int QTR_W = IDX_W - 2;

    // First quarter of round(7.5 + 7.5*sin(2*pi*(k+0.5)/16)), entry 0 on the right
    parameter logic [2**QTR_W-1:0][LEVEL_W-1:0] QUARTER_WAVE = {
        4'd15,
        4'd14,
        4'd12,
        4'd9
    };

    // Config port handshake states
    typedef enum logic [1:0] {
        IDLE,     // ack low, waiting for req
        ACK,      // Settings latched on entry, ack high
        WAIT_LOW  // ack held high until the host drops req
    } cfg_state_t;

endpackage

// File: list.f
common/sinvar_pkg.sv
rtl/cfg_port.sv
rtl/tick_prescaler.sv
pwm/pwm_sequencer.sv
pwm/sine_table.sv
pwm/pwm_modulator.sv
rtl/sinvar_top.sv
tests/tb_sinvar.sv

// File: pwm/pwm_modulator.sv
`timescale 1ns/100ps

module pwm_modulator (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enable,
    input  logic                           tick,
    input  logic [sinvar_pkg::LEVEL_W-1:0] pos,
    input  logic [sinvar_pkg::LEVEL_W-1:0] level,
    output logic                           pwm_out
);

    logic on_phase;

    // Thermometer decode as a compare, level d keeps the first d+1 ticks high
    assign on_phase = (pos <= level);

    always_ff @(posedge clk) begin
        if (!rst || !enable) begin
            pwm_out <= 1'b0;
        end else if (tick) begin
            pwm_out <= on_phase;  // Holds its value between ticks
        end
    end

endmodule

// File: pwm/pwm_sequencer.sv
`timescale 1ns/100ps

module pwm_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enable,
    input  logic                           tick,
    output logic [sinvar_pkg::LEVEL_W-1:0] pos,
    output logic [sinvar_pkg::IDX_W-1:0]   idx,
    output logic                           period_start
);

    logic frame_end;
    logic period_end;

    // Last tick of a frame moves on to the next sample
    assign frame_end  = tick && (pos == '1);
    assign period_end = frame_end && (idx == '1);

    always_ff @(posedge clk) begin
        if (!rst || !enable) begin
            pos          <= '0;
            idx          <= '0;
            period_start <= 1'b0;
        end else begin
            if (tick) begin
                pos <= pos + 1'b1;  // Wraps 15 to 0 on its own
            end

            if (frame_end) begin
                idx <= idx + 1'b1;
            end

            // Pulse lands on the cycle after the tick that wraps idx
            period_start <= period_end;
        end
    end

    // The sample index moves only at a frame boundary, or is cleared by enable
    idx_on_frame_end: assert property (
        @(posedge clk) disable iff (!rst)
        (idx != $past(idx)) |-> ($past(frame_end) || !$past(enable))
    ) else $error("idx changed outside a frame boundary");

    // One period_start per wrap of idx, never two cycles running
    period_pulse_width: assert property (
        @(posedge clk) disable iff (!rst)
        period_start |=> !period_start
    ) else $error("period_start longer than one cycle");

endmodule

// File: pwm/sine_table.sv
`timescale 1ns/100ps

module sine_table (
    input  logic [sinvar_pkg::IDX_W-1:0]   idx,
    output logic [sinvar_pkg::LEVEL_W-1:0] level
);
    import sinvar_pkg::*;

    logic             mirror;
    logic             invert;
    logic [QTR_W-1:0] qtr_idx;
    logic [LEVEL_W-1:0] qtr_level;

    // Top two index bits pick the quadrant
    // Quadrants 1 and 3 run the quarter table backwards
    assign mirror = idx[IDX_W-2];

    // Quadrants 2 and 3 are the lower half of the wave
    assign invert = idx[IDX_W-1];

    always_comb begin
        if (mirror) begin
            qtr_idx = ~idx[QTR_W-1:0];  // 3 - k
        end else begin
            qtr_idx = idx[QTR_W-1:0];
        end
    end

    assign qtr_level = QUARTER_WAVE[qtr_idx];

    // 15 minus the table value is a plain bit inversion at this width
    always_comb begin
        if (invert) begin
            level = ~qtr_level;
        end else begin
            level = qtr_level;
        end
    end

endmodule

// File: rtl/cfg_port.sv
`timescale 1ns/100ps

module cfg_port (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cfg_req,
    input  logic [sinvar_pkg::PRESCALE_W-1:0] cfg_prescale,
    input  logic                              cfg_enable,
    output logic                              cfg_ack,
    output logic [sinvar_pkg::PRESCALE_W-1:0] prescale,
    output logic                              enable
);
    import sinvar_pkg::*;

    cfg_state_t state;

    // Four-phase receiver, the host keeps its data stable while req is high
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= IDLE;
            prescale <= '0;
            enable   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cfg_req) begin
                        state    <= ACK;
                        prescale <= cfg_prescale;  // Takes effect next cycle
                        enable   <= cfg_enable;
                    end
                end
                ACK: begin
                    // A host that drops req at once skips the wait state
                    if (cfg_req) begin
                        state <= WAIT_LOW;
                    end else begin
                        state <= IDLE;
                    end
                end
                WAIT_LOW: begin
                    if (!cfg_req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Ack is high in every state but IDLE and comes straight from the state register
    assign cfg_ack = (state != IDLE);

    // A rising ack must answer a req that was already high at the previous edge
    ack_follows_req: assert property (
        @(posedge clk) disable iff (!rst)
        $rose(cfg_ack) |-> $past(cfg_req)
    ) else $error("cfg_ack rose without cfg_req");

endmodule

// File: rtl/sinvar_top.sv
`timescale 1ns/100ps

module sinvar_top #(
    parameter int DIV_W = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cfg_req,
    input  logic [sinvar_pkg::PRESCALE_W-1:0] cfg_prescale,
    input  logic                              cfg_enable,
    output logic                              cfg_ack,
    output logic                              pwm_out,
    output logic [sinvar_pkg::LEVEL_W-1:0]    level,
    output logic                              period_start
);
    import sinvar_pkg::*;

    logic [PRESCALE_W-1:0] prescale;
    logic                  enable;
    logic                  tick;
    logic [LEVEL_W-1:0]    pos;
    logic [IDX_W-1:0]      idx;

    cfg_port u_cfg_port (
        .clk          (clk),
        .rst          (rst),
        .cfg_req      (cfg_req),
        .cfg_prescale (cfg_prescale),
        .cfg_enable   (cfg_enable),
        .cfg_ack      (cfg_ack),
        .prescale     (prescale),
        .enable       (enable)
    );

    // Tick enable drives everything downstream, no derived clocks
    tick_prescaler #(
        .DIV_W (DIV_W)
    ) u_tick_prescaler (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .prescale (prescale),
        .tick     (tick)
    );

    pwm_sequencer u_pwm_sequencer (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .tick         (tick),
        .pos          (pos),
        .idx          (idx),
        .period_start (period_start)
    );

    sine_table u_sine_table (
        .idx   (idx),
        .level (level)  // Also brought out as a top port
    );

    pwm_modulator u_pwm_modulator (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .tick    (tick),
        .pos     (pos),
        .level   (level),
        .pwm_out (pwm_out)
    );

endmodule

// File: rtl/tick_prescaler.sv
`timescale 1ns/100ps

module tick_prescaler #(
    parameter int DIV_W = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic [sinvar_pkg::PRESCALE_W-1:0] prescale,
    output logic                              tick
);

    logic [DIV_W-1:0] count;
    logic [DIV_W-1:0] mask;
    logic [sinvar_pkg::PRESCALE_W-1:0] prescale_q;  // Setting the divider runs with

    // Low prescale bits set, so prescale 0 gives an empty mask and a tick every cycle
    assign mask = ~({DIV_W{1'b1}} << prescale_q);

    always_ff @(posedge clk) begin
        if (!rst || !enable) begin
            count      <= '0;
            tick       <= 1'b0;
            prescale_q <= prescale;
        end else if (prescale != prescale_q) begin
            // New rate restarts the divider from zero
            count      <= '0;
            tick       <= 1'b0;
            prescale_q <= prescale;
        end else begin
            count <= count + 1'b1;
            tick  <= ((count & mask) == mask);
        end
    end

    // Back-to-back ticks are only legal when dividing by one
    tick_spacing: assert property (
        @(posedge clk) disable iff (!rst)
        (tick && prescale_q != '0) |=> !tick
    ) else $error("tick high two cycles in a row with prescale %0d", prescale_q);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_sinvar -f list.f -j 0

./obj_dir/Vtb_sinvar | tee "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: tests/tb_sinvar.sv
`timescale 1ns/100ps

module tb_sinvar;
    import sinvar_pkg::*;

    localparam int DIV_W      = 8;
    localparam int NUM_WRITES = 6;

    logic                  clk;
    logic                  rst;
    logic                  cfg_req;
    logic [PRESCALE_W-1:0] cfg_prescale;
    logic                  cfg_enable;
    logic                  cfg_ack;
    logic                  pwm_out;
    logic [LEVEL_W-1:0]    level;
    logic                  period_start;

    // Full sine period of duty levels, sample 0 first
    logic [LEVEL_W-1:0] sine_ref [0:15] = '{4'd9, 4'd12, 4'd14, 4'd15, 4'd15, 4'd14, 4'd12,
        4'd9, 4'd6, 4'd3, 4'd1, 4'd0, 4'd0, 4'd1, 4'd3, 4'd6};

    // Reference model state, updated from the testbench's own inputs and the strobes
    logic [PRESCALE_W-1:0] exp_prescale;
    logic                  exp_enable;
    logic                  written;   // A write has started since reset
    logic                  settled;   // req was low at the previous edge
    logic [1:0]            ps_seen;   // period_start pulses since the last write, saturates at 2
    logic                  track;
    logic                  quiet;
    int                    ps_cnt;    // Cycles since the last period_start
    int                    run_cnt;
    int                    hi_cnt;    // High cycles so far in the current frame window
    int                    tick_len;
    int                    frame_len;
    int                    win;
    int                    win_pos;
    logic [3:0]            win_frame;
    logic [3:0]            samp;

    int          errors = 0;
    int          errors_before = 0;
    int          tests_run = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000000;
    logic [31:0] rand_state;
    logic [2:0]  rand_p;

    sinvar_top #(
        .DIV_W (DIV_W)
    ) u_sinvar_top (
        .clk          (clk),
        .rst          (rst),
        .cfg_req      (cfg_req),
        .cfg_prescale (cfg_prescale),
        .cfg_enable   (cfg_enable),
        .cfg_ack      (cfg_ack),
        .pwm_out      (pwm_out),
        .level        (level),
        .period_start (period_start)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Tracking starts at the second pulse after a write, once the new tick rate is steady
    assign track     = (ps_seen == 2'd2);
    assign quiet     = written && !exp_enable && settled;
    assign tick_len  = 1 << exp_prescale;
    assign frame_len = tick_len * 16;
    assign win       = run_cnt - tick_len;  // pwm_out lags the sample index by one tick
    assign win_pos   = win % frame_len;
    assign win_frame = 4'(win / frame_len);
    assign samp      = 4'((period_start ? 0 : ps_cnt) / frame_len);

    always @(posedge clk) begin
        if (!rst) begin
            exp_prescale <= '0;
            exp_enable   <= 1'b0;
            written      <= 1'b0;
            settled      <= 1'b0;
            ps_seen      <= 2'd0;
            ps_cnt       <= 0;
            run_cnt      <= 0;
            hi_cnt       <= 0;
        end else begin
            settled <= !cfg_req;
            if (cfg_req) begin
                exp_prescale <= cfg_prescale;
                exp_enable   <= cfg_enable;
                written      <= 1'b1;
                ps_seen      <= 2'd0;
            end else if (period_start && ps_seen != 2'd2) begin
                ps_seen <= ps_seen + 2'd1;
            end
            if (period_start) begin
                ps_cnt <= 1;
            end else begin
                ps_cnt <= ps_cnt + 1;
            end
            if (period_start && !track) begin
                run_cnt <= 1;
            end else begin
                run_cnt <= run_cnt + 1;
            end
            if (track && win >= 0) begin
                hi_cnt <= (win_pos == 0) ? int'(pwm_out) : hi_cnt + int'(pwm_out);
            end
        end
    end

    task automatic flag_error(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        errors++;
    endtask

    idle_outputs: assert property (@(posedge clk) disable iff (!rst)
        !written |-> (!cfg_ack && !pwm_out && !period_start)
    ) else flag_error("output active before the first config write");

    ack_rise_after_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(cfg_ack) |-> $past(cfg_req)
    ) else flag_error("cfg_ack rose without cfg_req high");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst)
        $fell(cfg_ack) |-> !$past(cfg_req)
    ) else flag_error("cfg_ack fell while cfg_req was still high");

    level_sequence: assert property (@(posedge clk) disable iff (!rst)
        track |-> level == sine_ref[samp]
    ) else flag_error("level does not match the sine table");

    duty_per_frame: assert property (@(posedge clk) disable iff (!rst)
        (track && win >= 0 && win_pos == frame_len - 1) |->
            (hi_cnt + int'(pwm_out)) == (int'(sine_ref[win_frame]) + 1) * tick_len
    ) else flag_error("pwm_out high time in a frame is not level+1 ticks");

    period_spacing: assert property (@(posedge clk) disable iff (!rst)
        (period_start && track) |-> ps_cnt == 256 * tick_len
    ) else flag_error("period_start spacing is not 256 ticks");

    disabled_outputs: assert property (@(posedge clk) disable iff (!rst)
        quiet |-> (!pwm_out && !period_start && level == 4'd9)
    ) else flag_error("outputs not parked while disabled");

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Four-phase write, entered and left 10 ns after a rising edge
    task automatic write_config(input logic [2:0] p, input logic en);
        int waited;
        cfg_prescale = p;
        cfg_enable   = en;
        cfg_req      = 1'b1;
        waited       = 0;
        while (!cfg_ack && waited < 20) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (!cfg_ack) begin
            $display("Handshake error: cfg_ack never rose for prescale %0d", p);
            errors++;
        end
        cfg_req = 1'b0;
        waited  = 0;
        while (cfg_ack && waited < 20) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (cfg_ack) begin
            $display("Handshake error: cfg_ack stayed high after cfg_req dropped");
            errors++;
        end
    endtask

    task automatic wait_periods(input int n, input logic [2:0] p);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            #10;
            if (period_start) begin
                seen++;
            end
        end
        repeat (16 << p) @(posedge clk);  // Lets the last frame window close
        #10;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rst          = 1'b0;
        cfg_req      = 1'b0;
        cfg_prescale = '0;
        cfg_enable   = 1'b0;
        rand_state   = 32'd89553;
        rand_state   = lcg_step(rand_state);
        rand_p       = rand_state[18:16];
        // Each PWM test needs up to four sine periods of 256 ticks
        cycle_limit = 30 + NUM_WRITES * 50 + 4 * 256 + ((4 * 256) << rand_p)
            + 4 * 256 * 255 + 1000;
        cycle_limit = cycle_limit * 3 / 2;

        repeat (10) @(posedge clk);
        #10;
        rst = 1'b1;

        repeat (20) @(posedge clk);
        #10;
        report_test("idle after reset");

        for (int i = 0; i < NUM_WRITES; i++) begin
            rand_state = lcg_step(rand_state);
            write_config(rand_state[18:16], 1'b1);
        end
        report_test("back-to-back writes");

        write_config(3'd0, 1'b1);
        wait_periods(3, 3'd0);
        report_test("sine sequence at prescale 0");

        write_config(rand_p, 1'b1);
        wait_periods(3, rand_p);
        report_test("duty at random prescale");

        for (int p = 0; p < 8; p++) begin
            write_config(3'(p), 1'b1);
            wait_periods(3, 3'(p));
        end
        report_test("period spacing for all prescales");

        write_config(3'd5, 1'b0);
        repeat (1000) @(posedge clk);
        #10;
        report_test("disabled output");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
